/* hw/cpu_defines.svh */
// word-only MIPS subset; the reset PC must match where the program image is loaded
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

`define XLEN        32
`define REG_ADDR_W  5
`define REG_COUNT   32
`define RESET_PC    32'h0000_3000

// primary opcodes of the supported instructions
`define OP_RTYPE    6'b000000
`define OP_ORI      6'b001101
`define OP_LUI      6'b001111
`define OP_LW       6'b100011
`define OP_SW       6'b101011
`define OP_BEQ      6'b000100

// funct codes under OP_RTYPE
`define FN_ADDU     6'b100001
`define FN_SUBU     6'b100011

`endif

/* hw/cpu_pkg.sv */
// field layout follows the MIPS32 encoding; only the addu/subu/ori/lui/lw/sw/beq subset
`include "cpu_defines.svh"

package cpu_pkg;

    typedef union packed {
        struct packed {
            logic [5:0]             opcode;
            logic [`REG_ADDR_W-1:0] rs;
            logic [`REG_ADDR_W-1:0] rt;
            logic [`REG_ADDR_W-1:0] rd;
            logic [4:0]             shamt;
            logic [5:0]             funct;
        } rType;
        struct packed {
            logic [5:0]             opcode;
            logic [`REG_ADDR_W-1:0] rs;
            logic [`REG_ADDR_W-1:0] rt;
            logic [15:0]            imm;
        } iType;
    } instWord_u;

    typedef enum logic [1:0] {ALU_ADD, ALU_SUB, ALU_OR, ALU_LUI} aluOp_e;

    typedef enum logic {WB_ALU, WB_MEM} wbSel_e;

    typedef struct packed {
        aluOp_e                 aluOp;
        logic                   immSel;   // alu input 2 is the immediate
        logic                   memWrite;
        logic                   memRead;
        logic                   regWrite; // never set for r0
        logic [`REG_ADDR_W-1:0] target;
        wbSel_e                 wbSel;
    } ctrl_s;

    // nearest ready producer with a matching target wins
    function automatic logic [`XLEN-1:0] pickOperand(
        input logic [`REG_ADDR_W-1:0] num,
        input logic [`XLEN-1:0]       regVal,
        input logic                   mWe,
        input logic                   mReady,
        input logic [`REG_ADDR_W-1:0] mTarget,
        input logic [`XLEN-1:0]       mData,
        input logic                   wWe,
        input logic                   wReady,
        input logic [`REG_ADDR_W-1:0] wTarget,
        input logic [`XLEN-1:0]       wData
    );
        if (mWe && mReady && mTarget == num) begin
            return mData;
        end
        if (wWe && wReady && wTarget == num) begin
            return wData;
        end
        return regVal;
    endfunction

endpackage

/* hw/fwdBusIf.sv */
// one pending register write; we is only ever set for a nonzero target
`timescale 1ns/1ps
`include "cpu_defines.svh"

interface fwdBusIf;
    logic                   we;
    logic [`REG_ADDR_W-1:0] target;
    logic [`XLEN-1:0]       data;
    logic                   ready;  // low while a load has no data yet

    modport driver (
        output we, target, data, ready
    );

    modport consumer (
        input we, target, data, ready
    );
endinterface

/* hw/ctrlDecoder.sv */
// unknown opcodes and funct codes decode to a nop, no illegal instruction trap
`timescale 1ns/1ps
`include "cpu_defines.svh"

module ctrlDecoder
    import cpu_pkg::*;
(
    input  instWord_u dInst,
    output ctrl_s     ctrl,
    output logic      useRsAtD,  // needed by the branch compare
    output logic      useRtAtD,
    output logic      useRs,
    output logic      useRt
);
    always_comb begin
        ctrl = '0;
        useRsAtD = 1'b0;
        useRtAtD = 1'b0;
        useRs = 1'b0;
        useRt = 1'b0;
        case (dInst.rType.opcode)
            `OP_RTYPE: begin
                if (dInst.rType.funct == `FN_ADDU || dInst.rType.funct == `FN_SUBU) begin
                    ctrl.aluOp = (dInst.rType.funct == `FN_SUBU) ? ALU_SUB : ALU_ADD;
                    ctrl.regWrite = 1'b1;
                    ctrl.target = dInst.rType.rd;
                    useRs = 1'b1;
                    useRt = 1'b1;
                end
            end
            `OP_ORI, `OP_LUI, `OP_LW: begin
                ctrl.aluOp = (dInst.iType.opcode == `OP_ORI) ? ALU_OR :
                             (dInst.iType.opcode == `OP_LUI) ? ALU_LUI : ALU_ADD;
                ctrl.immSel = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.target = dInst.iType.rt;
                ctrl.memRead = (dInst.iType.opcode == `OP_LW);
                ctrl.wbSel = (dInst.iType.opcode == `OP_LW) ? WB_MEM : WB_ALU;
                useRs = (dInst.iType.opcode != `OP_LUI);  // lui ignores rs
            end
            `OP_SW: begin
                ctrl.immSel = 1'b1;
                ctrl.memWrite = 1'b1;
                useRs = 1'b1;
                useRt = 1'b1;
            end
            `OP_BEQ: begin
                useRsAtD = 1'b1;
                useRtAtD = 1'b1;
                useRs = 1'b1;
                useRt = 1'b1;
            end
            default: ;
        endcase
        if (ctrl.target == '0) begin
            ctrl.regWrite = 1'b0;  // writes to r0 vanish here
        end
    end
endmodule

/* hw/regFile.sv */
// r0 reads as zero; a write in the same cycle is visible on the read ports
`timescale 1ns/1ps
`include "cpu_defines.svh"

module regFile (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [`REG_ADDR_W-1:0] rsNum,
    input  logic [`REG_ADDR_W-1:0] rtNum,
    output logic [`XLEN-1:0]       rsRead,
    output logic [`XLEN-1:0]       rtRead,
    fwdBusIf.consumer              wBus
);
    logic [`XLEN-1:0] regs [`REG_COUNT];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wBus.we) begin
            regs[wBus.target] <= wBus.data;
        end
    end

    assign rsRead = (rsNum == '0) ? '0 :
                    (wBus.we && wBus.target == rsNum) ? wBus.data : regs[rsNum];
    assign rtRead = (rtNum == '0) ? '0 :
                    (wBus.we && wBus.target == rtNum) ? wBus.data : regs[rtNum];
endmodule

/* hw/hazardUnit.sv */
// only data hazards; branches have a delay slot so nothing is flushed
`timescale 1ns/1ps
`include "cpu_defines.svh"

module hazardUnit (
    input  logic                   useRsAtD,
    input  logic                   useRtAtD,
    input  logic                   useRs,
    input  logic                   useRt,
    input  logic [`REG_ADDR_W-1:0] rsNum,
    input  logic [`REG_ADDR_W-1:0] rtNum,
    input  logic                   eWe,
    input  logic [`REG_ADDR_W-1:0] eTarget,
    input  logic                   eIsLoad,
    fwdBusIf.consumer              mBus,
    output logic                   stall
);
    logic rsFromE;
    logic rtFromE;
    logic rsFromM;
    logic rtFromM;

    // producer in execute: branch operands always wait, others only for a load
    assign rsFromE = useRs && eWe && eTarget == rsNum && (useRsAtD || eIsLoad);
    assign rtFromE = useRt && eWe && eTarget == rtNum && (useRtAtD || eIsLoad);
    // beq against a load that is still in memory
    assign rsFromM = useRsAtD && mBus.we && !mBus.ready && mBus.target == rsNum;
    assign rtFromM = useRtAtD && mBus.we && !mBus.ready && mBus.target == rtNum;
    assign stall = rsFromE || rtFromE || rsFromM || rtFromM;
endmodule

/* hw/frontEnd.sv */
// beq resolves in decode with one delay slot; a stall holds PC and the F/D register
`timescale 1ns/1ps
`include "cpu_defines.svh"

module frontEnd
    import cpu_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   stall,
    output logic [`XLEN-1:0]       instAddr,
    input  logic [`XLEN-1:0]       instRdata,
    output logic [`REG_ADDR_W-1:0] rsNum,
    output logic [`REG_ADDR_W-1:0] rtNum,
    input  logic [`XLEN-1:0]       rsRead,
    input  logic [`XLEN-1:0]       rtRead,
    input  ctrl_s                  ctrl,
    output instWord_u              dInst,
    fwdBusIf.consumer              mBus,
    fwdBusIf.consumer              wBus,
    output logic                   deValid,
    output logic [`XLEN-1:0]       dePc,
    output logic [`XLEN-1:0]       deRs,
    output logic [`XLEN-1:0]       deRt,
    output logic [`XLEN-1:0]       deImm,
    output ctrl_s                  deCtrl
);
    logic [`XLEN-1:0] pc;
    logic [`XLEN-1:0] nextPc;
    logic [`XLEN-1:0] fdPc;
    logic             fdValid;
    logic [15:0]      imm;
    logic             taken;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= `RESET_PC;
            fdValid <= 1'b0;
            dInst <= '0;  // nop until the first fetch lands
        end else if (!stall) begin
            pc <= nextPc;
            fdValid <= 1'b1;
            dInst <= instRdata;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            fdPc <= pc;
        end
    end

    assign instAddr = pc;
    assign rsNum = dInst.rType.rs;
    assign rtNum = dInst.rType.rt;
    assign imm = dInst.iType.imm;

    assign deRs = pickOperand(rsNum, rsRead, mBus.we, mBus.ready, mBus.target, mBus.data,
                              wBus.we, wBus.ready, wBus.target, wBus.data);
    assign deRt = pickOperand(rtNum, rtRead, mBus.we, mBus.ready, mBus.target, mBus.data,
                              wBus.we, wBus.ready, wBus.target, wBus.data);

    assign taken = dInst.iType.opcode == `OP_BEQ && deRs == deRt;
    // target is relative to the delay slot
    assign nextPc = taken ? fdPc + 4 + {{(`XLEN-18){imm[15]}}, imm, 2'b00} : pc + 4;

    // ori zero-extends, lui only looks at the low half
    assign deImm = (ctrl.aluOp == ALU_OR) ? {{(`XLEN-16){1'b0}}, imm} :
                                            {{(`XLEN-16){imm[15]}}, imm};
    assign dePc = fdPc;
    assign deCtrl = ctrl;
    assign deValid = fdValid && !stall;  // low means bubble into execute
endmodule

/* hw/backEnd.sv */
// word access only, low address bits are dropped; loads forward from writeback
`timescale 1ns/1ps
`include "cpu_defines.svh"

module backEnd
    import cpu_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   deValid,
    input  instWord_u              dInst,
    input  logic [`XLEN-1:0]       dePc,
    input  logic [`XLEN-1:0]       deRs,
    input  logic [`XLEN-1:0]       deRt,
    input  logic [`XLEN-1:0]       deImm,
    input  ctrl_s                  deCtrl,
    output logic                   eWe,
    output logic [`REG_ADDR_W-1:0] eTarget,
    output logic                   eIsLoad,
    fwdBusIf.driver                mBus,
    fwdBusIf.driver                wBus,
    output logic [`XLEN-1:0]       dataAddr,
    output logic [`XLEN-1:0]       dataWdata,
    output logic [`XLEN/8-1:0]     dataByteEn,
    input  logic [`XLEN-1:0]       dataRdata,
    output logic                   grfWe,
    output logic [`REG_ADDR_W-1:0] grfAddr,
    output logic [`XLEN-1:0]       grfWdata,
    output logic [`XLEN-1:0]       wbPc
);
    ctrl_s                  eCtrl;
    ctrl_s                  mCtrl;
    logic [`REG_ADDR_W-1:0] eRsNum;
    logic [`REG_ADDR_W-1:0] eRtNum;
    logic [`XLEN-1:0]       ePc, eRs, eRt, eImm;
    logic [`XLEN-1:0]       opA, opB, aluIn2, aluOut;
    logic [`XLEN-1:0]       mPc, mAlu, mStore;

    always_ff @(posedge clk) begin
        if (rst) begin
            eCtrl <= '0;
            mCtrl <= '0;
            grfWe <= 1'b0;
        end else begin
            eCtrl <= deValid ? deCtrl : '0;
            mCtrl <= eCtrl;
            grfWe <= mCtrl.regWrite;
        end
    end

    always_ff @(posedge clk) begin
        {ePc, eRs, eRt, eImm} <= {dePc, deRs, deRt, deImm};
        eRsNum <= dInst.rType.rs;
        eRtNum <= dInst.rType.rt;
        {mPc, mAlu, mStore} <= {ePc, aluOut, opB};
        grfAddr <= mCtrl.target;
        grfWdata <= (mCtrl.wbSel == WB_MEM) ? dataRdata : mAlu;
        wbPc <= mPc;
    end

    // values captured in decode may be stale by one or two instructions
    assign opA = pickOperand(eRsNum, eRs, mBus.we, mBus.ready, mBus.target, mBus.data,
                             wBus.we, wBus.ready, wBus.target, wBus.data);
    assign opB = pickOperand(eRtNum, eRt, mBus.we, mBus.ready, mBus.target, mBus.data,
                             wBus.we, wBus.ready, wBus.target, wBus.data);
    assign aluIn2 = eCtrl.immSel ? eImm : opB;

    always_comb begin
        case (eCtrl.aluOp)
            ALU_ADD: aluOut = opA + aluIn2;
            ALU_SUB: aluOut = opA - aluIn2;
            ALU_OR:  aluOut = opA | aluIn2;
            default: aluOut = {aluIn2[15:0], 16'b0};  // lui
        endcase
    end

    assign eWe = eCtrl.regWrite;
    assign eTarget = eCtrl.target;
    assign eIsLoad = eCtrl.memRead;

    assign mBus.we = mCtrl.regWrite;
    assign mBus.target = mCtrl.target;
    assign mBus.data = mAlu;
    assign mBus.ready = (mCtrl.wbSel == WB_ALU);  // load data not latched yet

    assign dataAddr = {mAlu[`XLEN-1:2], 2'b00};
    assign dataWdata = mStore;
    assign dataByteEn = {(`XLEN/8){mCtrl.memWrite}};

    assign wBus.we = grfWe;
    assign wBus.target = grfAddr;
    assign wBus.data = grfWdata;
    assign wBus.ready = 1'b1;
endmodule

/* hw/mipsCpu.sv */
// instruction and data memories are external and must answer in the same cycle
`timescale 1ns/1ps
`include "cpu_defines.svh"

module mipsCpu
    import cpu_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    output logic [`XLEN-1:0]       instAddr,
    input  logic [`XLEN-1:0]       instRdata,
    output logic [`XLEN-1:0]       dataAddr,
    output logic [`XLEN-1:0]       dataWdata,
    output logic [`XLEN/8-1:0]     dataByteEn,
    input  logic [`XLEN-1:0]       dataRdata,
    output logic                   grfWe,
    output logic [`REG_ADDR_W-1:0] grfAddr,
    output logic [`XLEN-1:0]       grfWdata,
    output logic [`XLEN-1:0]       wbPc
);
    logic                   stall;
    logic [`REG_ADDR_W-1:0] rsNum;
    logic [`REG_ADDR_W-1:0] rtNum;
    logic [`XLEN-1:0]       rsRead;
    logic [`XLEN-1:0]       rtRead;
    ctrl_s                  ctrl;
    instWord_u              dInst;
    logic                   useRsAtD;
    logic                   useRtAtD;
    logic                   useRs;
    logic                   useRt;
    logic                   deValid;
    logic [`XLEN-1:0]       dePc;
    logic [`XLEN-1:0]       deRs;
    logic [`XLEN-1:0]       deRt;
    logic [`XLEN-1:0]       deImm;
    ctrl_s                  deCtrl;
    logic                   eWe;
    logic [`REG_ADDR_W-1:0] eTarget;
    logic                   eIsLoad;

    fwdBusIf mBus ();  // from the E/M register
    fwdBusIf wBus ();  // from the M/W register

    frontEnd front (
        .clk, .rst, .stall, .instAddr, .instRdata, .rsNum, .rtNum, .rsRead, .rtRead,
        .ctrl, .dInst, .mBus, .wBus, .deValid, .dePc, .deRs, .deRt, .deImm, .deCtrl
    );

    ctrlDecoder decoder (.dInst, .ctrl, .useRsAtD, .useRtAtD, .useRs, .useRt);

    regFile regs (.clk, .rst, .rsNum, .rtNum, .rsRead, .rtRead, .wBus);

    hazardUnit hazard (
        .useRsAtD, .useRtAtD, .useRs, .useRt, .rsNum, .rtNum,
        .eWe, .eTarget, .eIsLoad, .mBus, .stall
    );

    backEnd back (
        .clk, .rst, .deValid, .dInst, .dePc, .deRs, .deRt, .deImm, .deCtrl,
        .eWe, .eTarget, .eIsLoad, .mBus, .wBus,
        .dataAddr, .dataWdata, .dataByteEn, .dataRdata,
        .grfWe, .grfAddr, .grfWdata, .wbPc
    );
endmodule

/* tb/mipsCpu_sva.sv */
// checks the top-level ports only; assumes word-only stores and r0 writes dropped in decode
`timescale 1ns/1ps
`include "cpu_defines.svh"

module mipsCpu_sva (
    input logic                   clk,
    input logic                   rst,
    input logic                   grfWe,
    input logic [`REG_ADDR_W-1:0] grfAddr,
    input logic [`XLEN/8-1:0]     dataByteEn
);
    noZeroWrite: assert property (@(posedge clk) disable iff (rst) grfWe |-> grfAddr != '0)
        else $error("register write to r0 on the trace port");

    // stores are all four bytes or nothing
    wordOnly: assert property (@(posedge clk) disable iff (rst)
        dataByteEn == '0 || dataByteEn == '1)
        else $error("partial byte enable %b", dataByteEn);

    quietInReset: assert property (@(posedge clk) rst |=> !grfWe && dataByteEn == '0)
        else $error("write activity while in reset");
endmodule

/* tb/mipsCpu_tb.sv */
// memories answer combinationally; imem holds 1024 words from RESET_PC and dmem 16 words at 0
`timescale 1ns/1ps
`include "cpu_defines.svh"

module mipsCpu_tb;
    localparam int IMEM_WORDS = 1024;
    localparam int TIMEOUT = 4000;

    logic                   clk = 1'b0;
    logic                   rst = 1'b1;
    logic [`XLEN-1:0]       instAddr;
    logic [`XLEN-1:0]       instRdata;
    logic [`XLEN-1:0]       dataAddr;
    logic [`XLEN-1:0]       dataWdata;
    logic [`XLEN/8-1:0]     dataByteEn;
    logic [`XLEN-1:0]       dataRdata;
    logic                   grfWe;
    logic [`REG_ADDR_W-1:0] grfAddr;
    logic [`XLEN-1:0]       grfWdata;
    logic [`XLEN-1:0]       wbPc;

    logic [31:0] imem [IMEM_WORDS];
    logic [31:0] dmem [16];
    logic [31:0] modelMem [16];
    logic [31:0] modelReg [32];
    logic [31:0] instIndex;
    logic [31:0] prog [$];
    logic [4:0]  expReg [$];
    logic [31:0] expData [$];
    logic [31:0] expPc [$];
    logic [31:0] expAddr [$];
    logic [31:0] expStore [$];
    int          bodyLen;
    int          gotW;
    int          gotS;
    int          testErrors;
    int          totalErrors;
    int          failedTests;
    int          testsRun;
    int          checks;
    integer      seed;

    mipsCpu DUT (
        .clk, .rst, .instAddr, .instRdata, .dataAddr, .dataWdata, .dataByteEn, .dataRdata,
        .grfWe, .grfAddr, .grfWdata, .wbPc
    );

    bind mipsCpu mipsCpu_sva sva (.clk, .rst, .grfWe, .grfAddr, .dataByteEn);

    always #5 clk = ~clk;

    assign instIndex = (instAddr - `RESET_PC) >> 2;
    assign instRdata = (instIndex < IMEM_WORDS) ? imem[instIndex[9:0]] : 32'h0;
    assign dataRdata = dmem[dataAddr[5:2]];

    always @(posedge clk) begin
        if (!rst && dataByteEn == 4'hf) begin
            dmem[dataAddr[5:2]] <= dataWdata;
        end
    end

    function automatic logic [31:0] encR(input int rs, input int rt, input int rd,
                                         input logic [5:0] fn);
        return {`OP_RTYPE, rs[4:0], rt[4:0], rd[4:0], 5'd0, fn};
    endfunction

    function automatic logic [31:0] encI(input logic [5:0] op, input int rs, input int rt,
                                         input int imm);
        return {op, rs[4:0], rt[4:0], imm[15:0]};
    endfunction

    function automatic logic [31:0] fillPattern(input logic [31:0] addr);
        return (addr * 32'h9e37_79b1) ^ {~addr[15:0], addr[15:0]};
    endfunction

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("mismatch %s: got %h expected %h", name, got, exp);
            testErrors++;
        end
    endtask

    // writeback trace and stores are compared in retirement order
    always @(negedge clk) begin
        if (!rst && grfWe) begin
            assert (gotW < expReg.size()) else begin
                $display("unexpected register write to r%0d from pc %h", grfAddr, wbPc);
                testErrors++;
            end
            if (gotW < expReg.size()) begin
                checkValue("grfAddr", 32'(grfAddr), 32'(expReg[gotW]));
                checkValue("grfWdata", grfWdata, expData[gotW]);
                checkValue("wbPc", wbPc, expPc[gotW]);
            end
            gotW++;
        end
        if (!rst && dataByteEn == 4'hf) begin
            assert (gotS < expAddr.size()) else begin
                $display("unexpected store to address %h", dataAddr);
                testErrors++;
            end
            if (gotS < expAddr.size()) begin
                checkValue("dataAddr", dataAddr, expAddr[gotS]);
                checkValue("dataWdata", dataWdata, expStore[gotS]);
            end
            gotS++;
        end
    end

    // sequential ISA model with a delay slot after every beq
    task automatic runModel();
        int          idx;
        int          nextIdx;
        int          newIdx;
        logic [31:0] w;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] simm;
        logic [31:0] addr;
        logic [31:0] res;
        logic [4:0]  dst;
        idx = 0;
        nextIdx = 1;
        for (int i = 0; i < 32; i++) begin
            modelReg[i] = 32'h0;
        end
        while (idx < bodyLen) begin
            w = prog[idx];
            a = modelReg[w[25:21]];
            b = modelReg[w[20:16]];
            simm = {{16{w[15]}}, w[15:0]};
            addr = a + simm;
            newIdx = nextIdx + 1;
            dst = 5'd0;
            res = 32'h0;
            case (w[31:26])
                `OP_RTYPE: begin
                    dst = (w[5:0] == `FN_ADDU || w[5:0] == `FN_SUBU) ? w[15:11] : 5'd0;
                    res = (w[5:0] == `FN_SUBU) ? a - b : a + b;
                end
                `OP_ORI: begin
                    dst = w[20:16];
                    res = a | {16'h0, w[15:0]};
                end
                `OP_LUI: begin
                    dst = w[20:16];
                    res = {w[15:0], 16'h0};
                end
                `OP_LW: begin
                    dst = w[20:16];
                    res = modelMem[addr[5:2]];
                end
                `OP_SW: begin
                    modelMem[addr[5:2]] = b;
                    expAddr.push_back({addr[31:2], 2'b00});
                    expStore.push_back(b);
                end
                `OP_BEQ: begin
                    if (a == b) begin
                        newIdx = idx + 1 + int'(simm);
                    end
                end
                default: ;
            endcase
            if (dst != 5'd0) begin
                modelReg[dst] = res;
                expReg.push_back(dst);
                expData.push_back(res);
                expPc.push_back(`RESET_PC + 32'(4 * idx));
            end
            idx = nextIdx;
            nextIdx = newIdx;
        end
    endtask

    task automatic makeRandomProgram(input int count);
        logic [31:0] r;
        logic        inDelay;
        int          rs;
        int          rt;
        int          rd;
        inDelay = 1'b0;
        for (int i = 0; i < count; i++) begin
            r = $random(seed);
            rs = int'(r[5:3]);  // r0..r7 keeps hazards frequent
            rt = int'(r[8:6]);
            rd = int'(r[11:9]);
            case (r[14:12])
                3'd0, 3'd1: prog.push_back(encR(rs, rt, rd, r[15] ? `FN_SUBU : `FN_ADDU));
                3'd2: prog.push_back(encI(`OP_ORI, rs, rt, int'(r[31:16])));
                3'd3: prog.push_back(encI(`OP_LUI, 0, rt, int'(r[31:16])));
                3'd4: prog.push_back(encI(`OP_LW, 0, rt, int'({r[19:16], 2'b00})));
                3'd5: prog.push_back(encI(`OP_SW, 0, rt, int'({r[19:16], 2'b00})));
                default: begin
                    if (!inDelay && i < count - 2) begin
                        prog.push_back(encI(`OP_BEQ, rs, rt, 1 + int'(r[16])));
                    end else begin
                        prog.push_back(encR(rs, rt, rd, `FN_ADDU));
                    end
                end
            endcase
            inDelay = (prog[i][31:26] == `OP_BEQ);
        end
    endtask

    task automatic runTest(input string name);
        int cycles;
        @(posedge clk);
        rst <= 1'b1;
        @(posedge clk);
        bodyLen = prog.size();
        prog.push_back(encI(`OP_BEQ, 0, 0, -1));  // park in a loop with a nop in the delay slot
        prog.push_back(32'h0);
        for (int i = 0; i < IMEM_WORDS; i++) begin
            imem[i] <= (i < prog.size()) ? prog[i] : 32'h0;
        end
        for (int i = 0; i < 16; i++) begin
            modelMem[i] = fillPattern(32'(4 * i));
            dmem[i] <= modelMem[i];
        end
        expReg.delete();
        expData.delete();
        expPc.delete();
        expAddr.delete();
        expStore.delete();
        runModel();
        testErrors = 0;
        gotW = 0;
        gotS = 0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        checkValue("instAddr", instAddr, `RESET_PC);
        repeat (4) begin  // nothing can retire before the fifth cycle
            checkValue("grfWe", 32'(grfWe), 32'h0);
            checkValue("dataByteEn", 32'(dataByteEn), 32'h0);
            @(negedge clk);
        end
        cycles = 0;
        while ((gotW < expReg.size() || gotS < expAddr.size()) && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        assert (cycles < TIMEOUT) else begin
            $display("timeout in %s after %0d of %0d writes and %0d of %0d stores",
                     name, gotW, expReg.size(), gotS, expAddr.size());
            testErrors++;
        end
        @(negedge clk);  // last store lands on the edge before
        for (int i = 0; i < 16; i++) begin
            checkValue($sformatf("dmem[%0d]", i), dmem[i], modelMem[i]);
        end
        testsRun++;
        totalErrors += testErrors;
        if (testErrors != 0) begin
            failedTests++;
        end
        $display("%s: %s, %0d writes, %0d stores, %0d errors", name,
                 (testErrors == 0) ? "ok" : "FAILED", gotW, gotS, testErrors);
        prog.delete();
    endtask

    initial begin
        seed = 32'hafa93047;
        runTest("reset");
        prog.push_back(encI(`OP_ORI, 0, 1, 'h1234));
        prog.push_back(encI(`OP_LUI, 0, 2, 'habcd));
        prog.push_back(encR(1, 2, 3, `FN_ADDU));
        prog.push_back(encR(3, 1, 4, `FN_SUBU));
        prog.push_back(encI(`OP_ORI, 4, 5, 'h00ff));
        prog.push_back(encR(5, 5, 6, `FN_ADDU));
        prog.push_back(encR(6, 3, 7, `FN_SUBU));
        prog.push_back(encI(`OP_LUI, 0, 1, 'h8000));
        prog.push_back(encR(1, 7, 2, `FN_ADDU));
        runTest("alu chain");
        prog.push_back(encI(`OP_LW, 0, 1, 4));
        prog.push_back(encR(1, 1, 2, `FN_ADDU));
        prog.push_back(encI(`OP_LW, 0, 3, 8));
        prog.push_back(encI(`OP_ORI, 3, 4, 1));
        prog.push_back(encI(`OP_SW, 0, 3, 20));
        prog.push_back(encI(`OP_LW, 0, 5, 20));
        prog.push_back(encR(5, 1, 6, `FN_SUBU));
        prog.push_back(encI(`OP_SW, 0, 6, 0));
        prog.push_back(encI(`OP_LW, 0, 7, 0));
        prog.push_back(encI(`OP_SW, 0, 7, 4));
        runTest("load use");
        prog.push_back(encI(`OP_ORI, 0, 1, 5));
        prog.push_back(encI(`OP_ORI, 0, 2, 5));
        prog.push_back(encI(`OP_BEQ, 1, 2, 2));  // taken and skips index 4
        prog.push_back(encI(`OP_ORI, 0, 3, 1));
        prog.push_back(encI(`OP_ORI, 0, 4, 2));
        prog.push_back(encI(`OP_ORI, 0, 5, 3));
        prog.push_back(encI(`OP_LW, 0, 6, 0));
        prog.push_back(encI(`OP_BEQ, 6, 1, 2));  // not taken
        prog.push_back(encI(`OP_ORI, 0, 7, 7));
        prog.push_back(encI(`OP_ORI, 0, 3, 9));
        prog.push_back(encR(1, 2, 1, `FN_SUBU));
        prog.push_back(encI(`OP_BEQ, 1, 0, 2));
        prog.push_back(encI(`OP_ORI, 0, 2, 'h22));
        prog.push_back(encI(`OP_ORI, 0, 4, 'h44));
        prog.push_back(encI(`OP_ORI, 0, 5, 'h55));
        runTest("branch");
        makeRandomProgram(200);
        runTest("random program");
        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 testsRun, failedTests, checks, totalErrors);
        if (failedTests == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end
endmodule

/* flist.f */
+incdir+hw
hw/cpu_pkg.sv
hw/fwdBusIf.sv
hw/ctrlDecoder.sv
hw/regFile.sv
hw/hazardUnit.sv
hw/frontEnd.sv
hw/backEnd.sv
hw/mipsCpu.sv
tb/mipsCpu_sva.sv
tb/mipsCpu_tb.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f flist.f --top-module mipsCpu_tb -Mdir obj_dir -o simv
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/simv > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q -x "Test completed successfully" sim.log; then
    exit 0
fi
exit 1
